//--- verilog.f
mips_isa_pkg.sv
pipe_pkg.sv
decoder.sv
reg_file.sv
hazard_unit.sv
execute_unit.sv
mycpu_top.sv
tb_mycpu_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mycpu_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_mycpu_top.sv
`timescale 1ns/1ps

module tb_mycpu_top;
    import mips_isa_pkg::*;

    localparam int WB_TIMEOUT = 50; // cycles allowed between two writebacks

    logic        aclk;
    logic        arst_n;
    logic [31:0] inst_addr, inst_rdata;
    logic        data_en, data_we;
    logic [31:0] data_addr, data_wdata, data_rdata;
    logic [31:0] wb_pc;
    logic [3:0]  wb_wen;
    logic [4:0]  wb_wnum;
    logic [31:0] wb_wdata;

    logic [31:0] rom [256];
    logic [31:0] ram [256];
    logic [31:0] exp_pc[$];
    int          exp_num[$];
    logic [31:0] exp_data[$];
    logic [63:0] stores[$];    // {addr, data} of each store seen in MEM
    logic [31:0] load_addrs[$]; // address of each load seen in MEM
    int          err_cnt;
    int          timeout_cnt;

    mycpu_top i_mycpu_top (
        .aclk                (aclk),
        .arst_n_i            (arst_n),
        .inst_addr_o         (inst_addr),
        .inst_rdata_i        (inst_rdata),
        .data_en_o           (data_en),
        .data_we_o           (data_we),
        .data_addr_o         (data_addr),
        .data_wdata_o        (data_wdata),
        .data_rdata_i        (data_rdata),
        .debug_wb_pc_o       (wb_pc),
        .debug_wb_rf_wen_o   (wb_wen),
        .debug_wb_rf_wnum_o  (wb_wnum),
        .debug_wb_rf_wdata_o (wb_wdata)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // combinational word-indexed memories
    assign inst_rdata = rom[inst_addr[9:2]];
    assign data_rdata = ram[data_addr[9:2]];

    initial begin
        for (int i = 0; i < 256; i++) begin
            ram[i] <= {24'hD0D0D0, i[7:0]}; // fill differs per word
        end
    end

    always @(posedge aclk) begin
        if (data_we) begin
            ram[data_addr[9:2]] <= data_wdata;
        end
    end

    always @(negedge aclk) begin
        if (data_we) begin
            stores.push_back({data_addr, data_wdata});
            check("store data_en", 32'(data_en), 32'h1);
        end else if (data_en) begin
            load_addrs.push_back(data_addr);
        end
    end

    task automatic check(input string what, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            err_cnt++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // arguments follow assembly order op rd, rs, rt
    function automatic logic [31:0] enc_r(input funct_e fn, input int rd, input int rs,
                                          input int rt, input int shamt);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], fn};
    endfunction

    function automatic logic [31:0] enc_i(input opcode_e op, input int rt, input int rs,
                                          input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] enc_j(input opcode_e op, input logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    task automatic expect_wb(input logic [31:0] pc, input int num, input logic [31:0] data);
        exp_pc.push_back(pc);
        exp_num.push_back(num);
        exp_data.push_back(data);
    endtask

    // holds the core in reset while a new program is loaded
    task automatic new_program();
        @(negedge aclk);
        arst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = 32'h0; // nop
        end
        exp_pc.delete();
        exp_num.delete();
        exp_data.delete();
        stores.delete();
        load_addrs.delete();
    endtask

    task automatic release_reset();
        repeat (5) @(negedge aclk);
        arst_n = 1'b1;
    endtask

    task automatic wait_wb(output logic seen);
        int cycles;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < WB_TIMEOUT) begin
            @(negedge aclk);
            cycles++;
            seen = (wb_wen != 4'h0);
        end
    endtask

    task automatic check_writebacks(input string test);
        logic seen;
        for (int i = 0; i < exp_pc.size(); i++) begin
            wait_wb(seen);
            if (!seen) begin
                timeout_cnt++;
                $display("%s: no register writeback within %0d cycles, expected %0d more",
                         test, WB_TIMEOUT, exp_pc.size() - i);
                return;
            end
            check({test, " wb pc"}, wb_pc, exp_pc[i]);
            check({test, " wb wnum"}, 32'(wb_wnum), exp_num[i]);
            check({test, " wb wdata"}, wb_wdata, exp_data[i]);
            check({test, " wb wen"}, 32'(wb_wen), 32'hF);
        end
        repeat (10) begin
            @(negedge aclk);
            check({test, " wen after last writeback"}, 32'(wb_wen), 32'h0);
        end
    endtask

    task automatic check_idle(input string what, input logic [31:0] pc);
        check({what, " wen"}, 32'(wb_wen), 32'h0);
        check({what, " data_en"}, 32'(data_en), 32'h0);
        check({what, " data_we"}, 32'(data_we), 32'h0);
        check({what, " inst_addr"}, inst_addr, pc);
    endtask

    task automatic test_reset();
        new_program();
        repeat (5) begin
            @(negedge aclk);
            check_idle("reset held", RESET_PC);
        end
        arst_n = 1'b1;
        #1;
        check_idle("first cycle after reset", RESET_PC);
        @(negedge aclk);
        check_idle("second cycle after reset", RESET_PC + 32'd4);
    endtask

    task automatic test_alu_chain();
        new_program();
        rom[0]  = enc_i(OP_ADDIU, 1, 0, 'h5);
        rom[1]  = enc_i(OP_ORI, 2, 1, 'hF0);     // r1 from MEM
        rom[2]  = enc_i(OP_LUI, 3, 0, 'h1234);
        rom[3]  = enc_r(FN_ADDU, 4, 3, 2, 0);    // MEM and WB together
        rom[4]  = enc_r(FN_SUBU, 5, 4, 1, 0);
        rom[5]  = enc_r(FN_AND, 6, 5, 2, 0);
        rom[6]  = enc_r(FN_OR, 7, 6, 3, 0);
        rom[7]  = enc_r(FN_XOR, 8, 7, 4, 0);
        rom[8]  = enc_r(FN_SLT, 9, 8, 6, 0);
        rom[9]  = enc_r(FN_SLL, 10, 0, 9, 4);
        rom[10] = enc_i(OP_ADDIU, 0, 10, 'h7);   // writes r0 so never retires
        rom[11] = enc_r(FN_ADDU, 11, 10, 0, 0);
        rom[12] = enc_i(OP_ADDIU, 12, 0, -1);
        rom[13] = enc_r(FN_SLT, 13, 12, 11, 0);  // signed compare
        expect_wb(RESET_PC + 32'h00, 1, 32'h0000_0005);
        expect_wb(RESET_PC + 32'h04, 2, 32'h0000_00F5);
        expect_wb(RESET_PC + 32'h08, 3, 32'h1234_0000);
        expect_wb(RESET_PC + 32'h0C, 4, 32'h1234_00F5);
        expect_wb(RESET_PC + 32'h10, 5, 32'h1234_00F0);
        expect_wb(RESET_PC + 32'h14, 6, 32'h0000_00F0);
        expect_wb(RESET_PC + 32'h18, 7, 32'h1234_00F0);
        expect_wb(RESET_PC + 32'h1C, 8, 32'h0000_0005);
        expect_wb(RESET_PC + 32'h20, 9, 32'h0000_0001);
        expect_wb(RESET_PC + 32'h24, 10, 32'h0000_0010);
        expect_wb(RESET_PC + 32'h2C, 11, 32'h0000_0010);
        expect_wb(RESET_PC + 32'h30, 12, 32'hFFFF_FFFF);
        expect_wb(RESET_PC + 32'h34, 13, 32'h0000_0001);
        release_reset();
        check_writebacks("alu chain");
    endtask

    task automatic test_memory();
        new_program();
        rom[0] = enc_i(OP_ADDIU, 1, 0, 'h40);
        rom[1] = enc_i(OP_LUI, 2, 0, 'hCAFE);
        rom[2] = enc_i(OP_ORI, 2, 2, 'hBEEF);
        rom[3] = enc_i(OP_SW, 2, 1, 'h8);        // store data forwarded from MEM
        rom[4] = enc_i(OP_LW, 3, 1, 'h8);
        rom[5] = enc_r(FN_ADDU, 4, 3, 1, 0);     // load-use with one bubble
        rom[6] = enc_i(OP_ADDIU, 5, 0, 'h3);
        expect_wb(RESET_PC + 32'h00, 1, 32'h0000_0040);
        expect_wb(RESET_PC + 32'h04, 2, 32'hCAFE_0000);
        expect_wb(RESET_PC + 32'h08, 2, 32'hCAFE_BEEF);
        expect_wb(RESET_PC + 32'h10, 3, 32'hCAFE_BEEF);
        expect_wb(RESET_PC + 32'h14, 4, 32'hCAFE_BF2F);
        expect_wb(RESET_PC + 32'h18, 5, 32'h0000_0003);
        release_reset();
        check_writebacks("memory");
        check("memory store count", stores.size(), 1);
        if (stores.size() > 0) begin
            check("memory store addr", stores[0][63:32], 32'h0000_0048);
            check("memory store data", stores[0][31:0], 32'hCAFE_BEEF);
        end
        check("memory load count", load_addrs.size(), 1);
        if (load_addrs.size() > 0) begin
            check("memory load addr", load_addrs[0], 32'h0000_0048);
        end
        check("memory ram word 18", ram[18], 32'hCAFE_BEEF);
    endtask

    task automatic test_branches();
        new_program();
        rom[0]  = enc_i(OP_ADDIU, 1, 0, 'h7);
        rom[1]  = enc_i(OP_ADDIU, 2, 0, 'h7);
        rom[2]  = enc_i(OP_BEQ, 2, 1, 3);        // taken to word 6
        rom[3]  = enc_i(OP_ADDIU, 3, 0, 'h1);    // delay slot
        rom[4]  = enc_i(OP_ADDIU, 4, 0, 'h2);    // squashed
        rom[5]  = enc_i(OP_ADDIU, 5, 0, 'h3);
        rom[6]  = enc_i(OP_ADDIU, 6, 0, 'h6);
        rom[7]  = enc_i(OP_BNE, 2, 1, 4);        // not taken
        rom[8]  = enc_i(OP_ADDIU, 7, 0, 'h8);
        rom[9]  = enc_i(OP_ADDIU, 8, 0, 'h9);
        expect_wb(RESET_PC + 32'h00, 1, 32'h7);
        expect_wb(RESET_PC + 32'h04, 2, 32'h7);
        expect_wb(RESET_PC + 32'h0C, 3, 32'h1);
        expect_wb(RESET_PC + 32'h18, 6, 32'h6);
        expect_wb(RESET_PC + 32'h20, 7, 32'h8);
        expect_wb(RESET_PC + 32'h24, 8, 32'h9);
        release_reset();
        check_writebacks("branches");
    endtask

    task automatic test_jumps();
        new_program();
        rom[0]  = enc_j(OP_JAL, RESET_PC + 32'h20);
        rom[1]  = enc_i(OP_ADDIU, 1, 0, 'h11);   // delay slot
        rom[2]  = enc_i(OP_ADDIU, 2, 0, 'h22);   // skipped
        rom[8]  = enc_i(OP_ADDIU, 3, 31, 'h4);   // link value via WB forward
        rom[9]  = enc_j(OP_J, RESET_PC + 32'h40);
        rom[10] = enc_i(OP_ADDIU, 4, 0, 'h44);
        rom[11] = enc_i(OP_ADDIU, 5, 0, 'h55);
        rom[16] = enc_i(OP_ADDIU, 6, 3, 'h1);
        expect_wb(RESET_PC + 32'h00, 31, RESET_PC + 32'h08);
        expect_wb(RESET_PC + 32'h04, 1, 32'h11);
        expect_wb(RESET_PC + 32'h20, 3, RESET_PC + 32'h0C);
        expect_wb(RESET_PC + 32'h28, 4, 32'h44);
        expect_wb(RESET_PC + 32'h40, 6, RESET_PC + 32'h0D);
        release_reset();
        check_writebacks("jumps");
    endtask

    initial begin
        arst_n = 1'b0;
        err_cnt = 0;
        timeout_cnt = 0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = 32'h0;
        end
        test_reset();
        test_alu_chain();
        test_memory();
        test_branches();
        test_jumps();
        $display("checks done: %0d errors, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- mycpu_top.sv
`timescale 1ns/1ps

module mycpu_top (
    input  logic                              aclk,
    input  logic                              arst_n_i,
    output logic [mips_isa_pkg::XLEN-1:0]       inst_addr_o,
    input  logic [mips_isa_pkg::XLEN-1:0]       inst_rdata_i,
    output logic                              data_en_o,
    output logic                              data_we_o,
    output logic [mips_isa_pkg::XLEN-1:0]       data_addr_o,
    output logic [mips_isa_pkg::XLEN-1:0]       data_wdata_o,
    input  logic [mips_isa_pkg::XLEN-1:0]       data_rdata_i,
    output logic [mips_isa_pkg::XLEN-1:0]       debug_wb_pc_o,
    output logic [3:0]                        debug_wb_rf_wen_o,
    output logic [mips_isa_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum_o,
    output logic [mips_isa_pkg::XLEN-1:0]       debug_wb_rf_wdata_o
);
    import mips_isa_pkg::*;
    import pipe_pkg::*;

    logic [XLEN-1:0]       pc, pc_next;
    logic [XLEN-1:0]       id_pc4, jump_target, branch_target;
    if_id_t                if_id;
    id_ex_t                id_ex;
    ex_mem_t               ex_mem;
    mem_wb_t               mem_wb;

    logic [XLEN-1:0]       id_instr;
    ctrl_t                 id_ctrl;
    logic [REG_ADDR_W-1:0] id_rs, id_rt, id_rd;
    logic [IMM_W-1:0]      id_imm;
    logic [XLEN-1:0]       id_imm32, rf_a, rf_b;

    logic                  stall, branch_taken;
    fwd_sel_e              fwd_a, fwd_b;
    logic [XLEN-1:0]       ex_alu_out, ex_store_data;
    logic [REG_ADDR_W-1:0] ex_dst;
    logic [XLEN-1:0]       mem_result, wb_result;
    logic                  wb_wen;

    // fetch
    assign inst_addr_o   = pc;
    assign id_pc4        = if_id.pc + 32'd4;
    assign jump_target   = {id_pc4[31:28], id_instr[25:0], 2'b00};
    assign branch_target = id_ex.pc + 32'd4 + {id_ex.imm32[XLEN-3:0], 2'b00};

    always_comb begin
        if (branch_taken) begin
            pc_next = branch_target;
        end else if (id_ctrl.jump) begin
            pc_next = jump_target; // delay slot is already in fetch
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            if_id <= '0;
        end else if (!stall) begin
            // taken branch kills the instruction after its delay slot
            if_id <= '{valid: !branch_taken, pc: pc, instr: inst_rdata_i};
        end
    end

    // decode, an empty slot decodes as sll r0 (nop)
    assign id_instr = if_id.valid ? if_id.instr : '0;
    assign id_rs    = id_instr[25:21];
    assign id_rt    = id_instr[20:16];
    assign id_rd    = id_instr[15:11];
    assign id_imm   = id_instr[IMM_W-1:0];
    assign id_imm32 = id_ctrl.sign_ext ? {{(XLEN-IMM_W){id_imm[IMM_W-1]}}, id_imm}
                                       : {{(XLEN-IMM_W){1'b0}}, id_imm};

    decoder i_decoder (
        .instr_i (id_instr),
        .ctrl_o  (id_ctrl)
    );

    reg_file i_reg_file (
        .aclk      (aclk),
        .arst_n_i  (arst_n_i),
        .rs_i      (id_rs),
        .rt_i      (id_rt),
        .rd_a_o    (rf_a),
        .rd_b_o    (rf_b),
        .wr_en_i   (wb_wen),
        .wr_addr_i (mem_wb.dst),
        .wr_data_i (wb_result)
    );

    hazard_unit i_hazard_unit (
        .id_ctrl_i (id_ctrl),
        .id_rs_i   (id_rs),
        .id_rt_i   (id_rt),
        .id_ex_i   (id_ex),
        .ex_mem_i  (ex_mem),
        .mem_wb_i  (mem_wb),
        .stall_o   (stall),
        .fwd_a_o   (fwd_a),
        .fwd_b_o   (fwd_b)
    );

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex <= '0;
        end else if (stall) begin
            id_ex <= '0; // bubble behind the load
        end else begin
            id_ex <= '{valid: if_id.valid, ctrl: id_ctrl, pc: if_id.pc,
                       bus_a: rf_a, bus_b: rf_b, imm32: id_imm32,
                       shamt: id_instr[10:6], rs: id_rs, rt: id_rt, rd: id_rd};
        end
    end

    // execute
    execute_unit i_execute_unit (
        .id_ex_i        (id_ex),
        .fwd_a_i        (fwd_a),
        .fwd_b_i        (fwd_b),
        .mem_fwd_i      (mem_result),
        .wb_fwd_i       (wb_result),
        .alu_out_o      (ex_alu_out),
        .store_data_o   (ex_store_data),
        .branch_taken_o (branch_taken)
    );

    always_comb begin
        case (id_ex.ctrl.dst_sel)
            DST_RT:  ex_dst = id_ex.rt;
            DST_RA:  ex_dst = RA_REG;
            default: ex_dst = id_ex.rd;
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= '{valid: id_ex.valid, pc: id_ex.pc, alu_out: ex_alu_out,
                        store_data: ex_store_data, dst: ex_dst,
                        reg_wr: id_ex.ctrl.reg_wr, mem_rd: id_ex.ctrl.mem_rd,
                        mem_wr: id_ex.ctrl.mem_wr, wb_sel: id_ex.ctrl.wb_sel};
        end
    end

    // memory
    assign data_en_o    = ex_mem.valid && (ex_mem.mem_rd || ex_mem.mem_wr);
    assign data_we_o    = ex_mem.valid && ex_mem.mem_wr;
    assign data_addr_o  = ex_mem.alu_out;
    assign data_wdata_o = ex_mem.store_data;

    // load data never forwards from here, the load-use stall covers it
    assign mem_result = (ex_mem.wb_sel == WB_LINK) ? ex_mem.pc + 32'd8 : ex_mem.alu_out;

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= '{valid: ex_mem.valid, pc: ex_mem.pc, alu_out: ex_mem.alu_out,
                        mem_data: data_rdata_i, dst: ex_mem.dst,
                        reg_wr: ex_mem.reg_wr, wb_sel: ex_mem.wb_sel};
        end
    end

    // writeback
    always_comb begin
        case (mem_wb.wb_sel)
            WB_MEM:  wb_result = mem_wb.mem_data;
            WB_LINK: wb_result = mem_wb.pc + 32'd8; // return past the delay slot
            default: wb_result = mem_wb.alu_out;
        endcase
    end

    assign wb_wen = mem_wb.valid && mem_wb.reg_wr && mem_wb.dst != '0;

    assign debug_wb_pc_o       = mem_wb.pc;
    assign debug_wb_rf_wen_o   = {4{wb_wen}};
    assign debug_wb_rf_wnum_o  = mem_wb.dst;
    assign debug_wb_rf_wdata_o = wb_result;

endmodule

//--- execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  pipe_pkg::id_ex_t            id_ex_i,
    input  pipe_pkg::fwd_sel_e          fwd_a_i,
    input  pipe_pkg::fwd_sel_e          fwd_b_i,
    input  logic [mips_isa_pkg::XLEN-1:0] mem_fwd_i,
    input  logic [mips_isa_pkg::XLEN-1:0] wb_fwd_i,
    output logic [mips_isa_pkg::XLEN-1:0] alu_out_o,
    output logic [mips_isa_pkg::XLEN-1:0] store_data_o,
    output logic                        branch_taken_o
);
    import mips_isa_pkg::*;
    import pipe_pkg::*;

    logic [XLEN-1:0] bus_a, bus_b; // after forwarding
    logic [XLEN-1:0] op_a, op_b;   // after source select

    function automatic logic [XLEN-1:0] pick(input fwd_sel_e sel,
                                             input logic [XLEN-1:0] reg_val);
        case (sel)
            FWD_MEM: return mem_fwd_i;
            FWD_WB:  return wb_fwd_i;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        bus_a = pick(fwd_a_i, id_ex_i.bus_a);
        bus_b = pick(fwd_b_i, id_ex_i.bus_b);
    end

    assign op_a = id_ex_i.ctrl.src_a_shamt ? {{(XLEN-SHAMT_W){1'b0}}, id_ex_i.shamt} : bus_a;
    assign op_b = id_ex_i.ctrl.src_b_imm ? id_ex_i.imm32 : bus_b;

    assign store_data_o = bus_b;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_ADD: alu_out_o = op_a + op_b;
            ALU_SUB: alu_out_o = op_a - op_b;
            ALU_AND: alu_out_o = op_a & op_b;
            ALU_OR:  alu_out_o = op_a | op_b;
            ALU_XOR: alu_out_o = op_a ^ op_b;
            ALU_SLT: alu_out_o = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLL: alu_out_o = op_b << op_a[SHAMT_W-1:0];
            ALU_LUI: alu_out_o = {op_b[15:0], 16'h0000};
            default: alu_out_o = '0;
        endcase
    end

    assign branch_taken_o = id_ex_i.valid &&
                            ((id_ex_i.ctrl.branch == BR_BEQ && bus_a == bus_b) ||
                             (id_ex_i.ctrl.branch == BR_BNE && bus_a != bus_b));

endmodule

//--- hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  pipe_pkg::ctrl_t                   id_ctrl_i,
    input  logic [mips_isa_pkg::REG_ADDR_W-1:0] id_rs_i,
    input  logic [mips_isa_pkg::REG_ADDR_W-1:0] id_rt_i,
    input  pipe_pkg::id_ex_t                  id_ex_i,
    input  pipe_pkg::ex_mem_t                 ex_mem_i,
    input  pipe_pkg::mem_wb_t                 mem_wb_i,
    output logic                              stall_o,
    output pipe_pkg::fwd_sel_e                fwd_a_o,
    output pipe_pkg::fwd_sel_e                fwd_b_o
);
    import mips_isa_pkg::*;
    import pipe_pkg::*;

    logic load_in_ex;

    // youngest producer wins and r0 never forwards
    function automatic fwd_sel_e fwd_src(input logic [REG_ADDR_W-1:0] src);
        if (ex_mem_i.valid && ex_mem_i.reg_wr &&
            ex_mem_i.dst != '0 && ex_mem_i.dst == src) begin
            return FWD_MEM;
        end
        if (mem_wb_i.valid && mem_wb_i.reg_wr &&
            mem_wb_i.dst != '0 && mem_wb_i.dst == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwd_a_o = fwd_src(id_ex_i.rs);
        fwd_b_o = fwd_src(id_ex_i.rt);
    end

    // load data only exists at the end of MEM so the consumer waits a cycle
    assign load_in_ex = id_ex_i.valid && id_ex_i.ctrl.mem_rd && id_ex_i.rt != '0;

    assign stall_o = load_in_ex &&
                     ((id_ctrl_i.uses_rs && id_rs_i == id_ex_i.rt) ||
                      (id_ctrl_i.uses_rt && id_rt_i == id_ex_i.rt));

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                              aclk,
    input  logic                              arst_n_i,
    input  logic [mips_isa_pkg::REG_ADDR_W-1:0] rs_i,
    input  logic [mips_isa_pkg::REG_ADDR_W-1:0] rt_i,
    output logic [mips_isa_pkg::XLEN-1:0]       rd_a_o,
    output logic [mips_isa_pkg::XLEN-1:0]       rd_b_o,
    input  logic                              wr_en_i,
    input  logic [mips_isa_pkg::REG_ADDR_W-1:0] wr_addr_i,
    input  logic [mips_isa_pkg::XLEN-1:0]       wr_data_i
);
    import mips_isa_pkg::*;

    logic [XLEN-1:0] regs [32]; // regs[0] is never written

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // write-through, WB result visible to ID in the same cycle
    assign rd_a_o = (rs_i == '0) ? '0 :
                    (wr_en_i && wr_addr_i == rs_i) ? wr_data_i : regs[rs_i];
    assign rd_b_o = (rt_i == '0) ? '0 :
                    (wr_en_i && wr_addr_i == rt_i) ? wr_data_i : regs[rt_i];

endmodule

//--- decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic [mips_isa_pkg::XLEN-1:0] instr_i,
    output pipe_pkg::ctrl_t             ctrl_o
);
    import mips_isa_pkg::*;
    import pipe_pkg::*;

    opcode_e opcode;
    funct_e  funct;

    assign opcode = opcode_e'(instr_i[31:26]);
    assign funct  = funct_e'(instr_i[5:0]);

    always_comb begin
        ctrl_o = '0;
        case (opcode)
            OP_SPECIAL: begin
                ctrl_o.dst_sel = DST_RD;
                ctrl_o.reg_wr  = 1'b1;
                ctrl_o.uses_rs = 1'b1;
                ctrl_o.uses_rt = 1'b1;
                case (funct)
                    FN_ADDU: ctrl_o.alu_op = ALU_ADD;
                    FN_SUBU: ctrl_o.alu_op = ALU_SUB;
                    FN_AND:  ctrl_o.alu_op = ALU_AND;
                    FN_OR:   ctrl_o.alu_op = ALU_OR;
                    FN_XOR:  ctrl_o.alu_op = ALU_XOR;
                    FN_SLT:  ctrl_o.alu_op = ALU_SLT;
                    FN_SLL: begin
                        ctrl_o.alu_op      = ALU_SLL;
                        ctrl_o.src_a_shamt = 1'b1;
                        ctrl_o.uses_rs     = 1'b0; // rs field unused by shifts
                    end
                    default: ctrl_o = '0;          // unknown funct acts as nop
                endcase
            end
            OP_ADDIU, OP_ORI, OP_LUI, OP_LW: begin
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.dst_sel   = DST_RT;
                ctrl_o.reg_wr    = 1'b1;
                ctrl_o.uses_rs   = (opcode != OP_LUI);
                ctrl_o.sign_ext  = (opcode == OP_ADDIU) || (opcode == OP_LW);
                if (opcode == OP_ORI) begin
                    ctrl_o.alu_op = ALU_OR;
                end else if (opcode == OP_LUI) begin
                    ctrl_o.alu_op = ALU_LUI;
                end else begin
                    ctrl_o.alu_op = ALU_ADD;
                end
                if (opcode == OP_LW) begin
                    ctrl_o.wb_sel = WB_MEM;
                    ctrl_o.mem_rd = 1'b1;
                end
            end
            OP_SW: begin
                ctrl_o.alu_op    = ALU_ADD;   // base + offset
                ctrl_o.src_b_imm = 1'b1;
                ctrl_o.sign_ext  = 1'b1;
                ctrl_o.mem_wr    = 1'b1;
                ctrl_o.uses_rs   = 1'b1;
                ctrl_o.uses_rt   = 1'b1;      // store data
            end
            OP_BEQ, OP_BNE: begin
                ctrl_o.branch   = (opcode == OP_BEQ) ? BR_BEQ : BR_BNE;
                ctrl_o.sign_ext = 1'b1;
                ctrl_o.uses_rs  = 1'b1;
                ctrl_o.uses_rt  = 1'b1;
            end
            OP_J: ctrl_o.jump = 1'b1;
            OP_JAL: begin
                ctrl_o.jump    = 1'b1;
                ctrl_o.dst_sel = DST_RA;
                ctrl_o.wb_sel  = WB_LINK;
                ctrl_o.reg_wr  = 1'b1;
            end
            default: ctrl_o = '0;
        endcase
    end

endmodule

//--- pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {BR_NONE, BR_BEQ, BR_BNE} branch_e;
    typedef enum logic [1:0] {DST_RD, DST_RT, DST_RA} dst_sel_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_e;
    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;

    // all-zero word is a harmless nop
    typedef struct packed {
        alu_op_e  alu_op;
        logic     src_b_imm;   // operand b from imm32
        logic     src_a_shamt; // operand a from shamt
        logic     sign_ext;
        dst_sel_e dst_sel;
        wb_sel_e  wb_sel;
        logic     reg_wr;
        logic     mem_rd;
        logic     mem_wr;
        branch_e  branch;
        logic     jump;
        logic     uses_rs;     // for load-use detection
        logic     uses_rt;
    } ctrl_t;

    typedef struct packed {
        logic                        valid;
        logic [mips_isa_pkg::XLEN-1:0] pc;
        logic [mips_isa_pkg::XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                              valid;
        ctrl_t                             ctrl;
        logic [mips_isa_pkg::XLEN-1:0]       pc;
        logic [mips_isa_pkg::XLEN-1:0]       bus_a;
        logic [mips_isa_pkg::XLEN-1:0]       bus_b;
        logic [mips_isa_pkg::XLEN-1:0]       imm32;
        logic [mips_isa_pkg::SHAMT_W-1:0]    shamt;
        logic [mips_isa_pkg::REG_ADDR_W-1:0] rs;
        logic [mips_isa_pkg::REG_ADDR_W-1:0] rt;
        logic [mips_isa_pkg::REG_ADDR_W-1:0] rd;
    } id_ex_t;

    typedef struct packed {
        logic                              valid;
        logic [mips_isa_pkg::XLEN-1:0]       pc;
        logic [mips_isa_pkg::XLEN-1:0]       alu_out;    // also the data address
        logic [mips_isa_pkg::XLEN-1:0]       store_data;
        logic [mips_isa_pkg::REG_ADDR_W-1:0] dst;
        logic                              reg_wr;
        logic                              mem_rd;
        logic                              mem_wr;
        wb_sel_e                           wb_sel;
    } ex_mem_t;

    typedef struct packed {
        logic                              valid;
        logic [mips_isa_pkg::XLEN-1:0]       pc;
        logic [mips_isa_pkg::XLEN-1:0]       alu_out;
        logic [mips_isa_pkg::XLEN-1:0]       mem_data;
        logic [mips_isa_pkg::REG_ADDR_W-1:0] dst;
        logic                              reg_wr;
        wb_sel_e                           wb_sel;
    } mem_wb_t;

endpackage

//--- mips_isa_pkg.sv
package mips_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;

    localparam logic [XLEN-1:0]       RESET_PC = 32'hBFC0_0000; // boot rom entry
    localparam logic [REG_ADDR_W-1:0] RA_REG   = 5'd31;         // link target of JAL

    // primary opcode, instr[31:26]
    typedef enum logic [OPCODE_W-1:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0D,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_e;

    // SPECIAL function field, instr[5:0]
    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL  = 6'h00,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A
    } funct_e;

endpackage
